// File: include/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath widths
`define EXU_XLEN 32
`define EXU_REG_ADDR_W 5
`define EXU_SHAMT_W 5

// word address into the on-chip srams, also the redirect width
`define EXU_SRAM_ADDR_W 12

// address bits that pick iram / oram / wram
`define EXU_REGION_LSB 12
`define EXU_REGION_MSB 13

// link address increment for jal / jalr
`define EXU_PC_STEP 4

`endif

// File: hdl/exu_pkg.sv
`default_nettype none

`include "exu_consts.svh"

package exu_pkg;

    // values double as op codes in the stimulus file, keep the order
    typedef enum logic [4:0] {
        op_add, op_sub, op_slt, op_sltu, op_xor, op_or, op_and,
        op_sll, op_srl, op_sra,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw
    } exu_op_e;

    // encoding follows the region bits of the address
    typedef enum logic [`EXU_REGION_MSB-`EXU_REGION_LSB:0] {
        region_iram = 2'd0,
        region_oram = 2'd1,
        region_wram = 2'd2,
        region_none = 2'd3
    } sram_region_e;

    function automatic logic is_load_op(exu_op_e op);
        return op inside {[op_lb:op_lhu]};
    endfunction

    function automatic logic is_store_op(exu_op_e op);
        return op inside {[op_sb:op_sw]};
    endfunction

    function automatic logic is_branch_op(exu_op_e op);
        return op inside {[op_beq:op_bgeu]};
    endfunction

endpackage

`default_nettype wire

// File: hdl/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module int_alu import exu_pkg::*; (
    input  exu_op_e                 op,
    input  logic [`EXU_XLEN-1:0]    src1,
    input  logic [`EXU_XLEN-1:0]    src2,
    input  logic [`EXU_XLEN-1:0]    pc,
    output logic [`EXU_XLEN-1:0]    result
);

    localparam logic [`EXU_XLEN-1:0] PC_STEP = `EXU_PC_STEP;

    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign shamt       = src2[`EXU_SHAMT_W-1:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            op_add:   result = src1 + src2;
            op_sub:   result = src1 - src2;
            op_slt:   result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
            op_sltu:  result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
            op_xor:   result = src1 ^ src2;
            op_or:    result = src1 | src2;
            op_and:   result = src1 & src2;
            op_sll:   result = src1 << shamt;
            op_srl:   result = src1 >> shamt;
            // sign fill
            op_sra:   result = $signed(src1) >>> shamt;
            // decoder already shifted the u-immediate into src2
            op_lui:   result = src2;
            op_auipc: result = pc + src2;
            op_jal,
            op_jalr:  result = pc + PC_STEP;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module branch_unit import exu_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            accept,
    input  exu_op_e                         op,
    input  logic [`EXU_XLEN-1:0]            src1,
    input  logic [`EXU_XLEN-1:0]            src2,
    input  logic [`EXU_XLEN-1:0]            imm,
    input  logic [`EXU_XLEN-1:0]            pc,
    output logic                            redirect_vld,
    output logic [`EXU_SRAM_ADDR_W-1:0]     redirect_addr
);

    logic                           taken;
    logic                           jump;
    logic [`EXU_SRAM_ADDR_W-1:0]    target;
    logic [`EXU_SRAM_ADDR_W-1:0]    pc_lo;
    logic [`EXU_SRAM_ADDR_W-1:0]    src1_lo;
    logic [`EXU_SRAM_ADDR_W-1:0]    src2_lo;
    logic [`EXU_SRAM_ADDR_W-1:0]    imm_lo;

    assign jump = (op == op_jal) || (op == op_jalr);

    always_comb begin
        case (op)
            op_beq:  taken = src1 == src2;
            op_bne:  taken = src1 != src2;
            op_blt:  taken = $signed(src1) < $signed(src2);
            op_bge:  taken = $signed(src1) >= $signed(src2);
            op_bltu: taken = src1 < src2;
            op_bgeu: taken = src1 >= src2;
            default: taken = 1'b0;
        endcase
    end

    // only the low bits of the target reach fetch, so add just those
    assign pc_lo   = pc[`EXU_SRAM_ADDR_W-1:0];
    assign src1_lo = src1[`EXU_SRAM_ADDR_W-1:0];
    assign src2_lo = src2[`EXU_SRAM_ADDR_W-1:0];
    assign imm_lo  = imm[`EXU_SRAM_ADDR_W-1:0];

    always_comb begin
        case (op)
            op_jal:  target = pc_lo + src2_lo;
            op_jalr: target = src1_lo + src2_lo;
            default: target = pc_lo + imm_lo;
        endcase
    end

    // single cycle pulse, accept is blocked while it is high
    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_vld <= 1'b0;
        end else begin
            redirect_vld <= accept & (taken | jump);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            redirect_addr <= target;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_agu.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module mem_agu import exu_pkg::*; (
    input  exu_op_e                         op,
    input  logic [`EXU_XLEN-1:0]            src1,
    input  logic [`EXU_XLEN-1:0]            src2,
    input  logic [`EXU_XLEN-1:0]            imm,
    output logic [`EXU_SRAM_ADDR_W-1:0]     addr,
    output sram_region_e                    region
);

    logic [`EXU_XLEN-1:0]   offset;
    // nothing above the region bits is needed
    logic [`EXU_REGION_MSB:0] sum;

    // loads take the offset in src2, stores in imm
    assign offset = is_store_op(op) ? imm : src2;
    assign sum    = src1[`EXU_REGION_MSB:0] + offset[`EXU_REGION_MSB:0];
    assign addr   = sum[`EXU_SRAM_ADDR_W-1:0];

    always_comb begin
        case (sum[`EXU_REGION_MSB:`EXU_REGION_LSB])
            2'b00:   region = region_iram;
            2'b01:   region = region_oram;
            2'b10:   region = region_wram;
            default: region = region_none;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/lsu_issue_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module lsu_issue_reg import exu_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  exu_op_e                         op,
    input  logic [`EXU_SRAM_ADDR_W-1:0]     addr,
    input  sram_region_e                    region,
    input  logic [`EXU_XLEN-1:0]            data,
    input  logic [`EXU_REG_ADDR_W-1:0]      wb_addr,
    input  logic                            wb_vld,
    input  logic                            lsu_rdy,
    output logic                            lsu_vld,
    output exu_op_e                         lsu_op,
    output logic [`EXU_SRAM_ADDR_W-1:0]     lsu_addr,
    output sram_region_e                    lsu_region,
    output logic [`EXU_XLEN-1:0]            lsu_data,
    output logic [`EXU_REG_ADDR_W-1:0]      lsu_wb_addr,
    output logic                            lsu_wb_vld
);

    logic lsu_vld_nxt;

    // hold while the lsu stalls, refill on a new memory op
    assign lsu_vld_nxt = load | (lsu_vld & ~lsu_rdy);

    always_ff @(posedge clk) begin
        if (rst) begin
            lsu_vld    <= 1'b0;
            lsu_wb_vld <= 1'b0;
        end else begin
            lsu_vld <= lsu_vld_nxt;
            if (load) begin
                lsu_wb_vld <= wb_vld;
            end
        end
    end

    // load only comes while lsu_rdy is high, so a held request is never overwritten
    always_ff @(posedge clk) begin
        if (load) begin
            lsu_op      <= op;
            lsu_addr    <= addr;
            lsu_region  <= region;
            lsu_data    <= data;
            lsu_wb_addr <= wb_addr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module exu_top import exu_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    // decoder side
    input  logic                            in_vld,
    input  exu_op_e                         op,
    input  logic                            rd_en,
    input  logic [`EXU_XLEN-1:0]            src1,
    input  logic [`EXU_XLEN-1:0]            src2,
    input  logic [`EXU_XLEN-1:0]            imm,
    input  logic [`EXU_XLEN-1:0]            pc,
    input  logic [`EXU_REG_ADDR_W-1:0]      wb_addr,
    output logic                            in_rdy,
    output logic                            flush_vld,
    output logic                            wb_vld,
    output logic [`EXU_REG_ADDR_W-1:0]      wb_addr_out,
    output logic [`EXU_XLEN-1:0]            wb_data,
    // fetch side
    output logic                            redirect_vld,
    output logic [`EXU_SRAM_ADDR_W-1:0]     redirect_addr,
    // lsu side
    input  logic                            lsu_rdy,
    output logic                            lsu_vld,
    output exu_op_e                         lsu_op,
    output logic [`EXU_SRAM_ADDR_W-1:0]     lsu_addr,
    output sram_region_e                    lsu_region,
    output logic [`EXU_XLEN-1:0]            lsu_data,
    output logic [`EXU_REG_ADDR_W-1:0]      lsu_wb_addr,
    output logic                            lsu_wb_vld
);

    logic                           accept;
    logic                           ld_op;
    logic                           st_op;
    logic                           br_op;
    logic                           mem_op;
    logic                           mem_accept;
    logic                           mem_wb_vld;
    logic [`EXU_XLEN-1:0]           alu_result;
    logic [`EXU_SRAM_ADDR_W-1:0]    agu_addr;
    sram_region_e                   agu_region;

    assign in_rdy = lsu_rdy;

    // the slot behind a taken branch or jump is dropped
    assign accept    = in_vld & in_rdy & ~redirect_vld;
    assign flush_vld = redirect_vld;

    assign ld_op  = is_load_op(op);
    assign st_op  = is_store_op(op);
    assign br_op  = is_branch_op(op);
    assign mem_op = ld_op | st_op;

    // everything that is not memory or branch writes back right away
    assign wb_vld      = accept & rd_en & ~(mem_op | br_op);
    assign wb_addr_out = wb_addr;
    assign wb_data     = alu_result;

    assign mem_accept = accept & mem_op;
    assign mem_wb_vld = rd_en & ld_op;

    int_alu int_alu_inst (
        .op     (op),
        .src1   (src1),
        .src2   (src2),
        .pc     (pc),
        .result (alu_result)
    );

    branch_unit branch_unit_inst (
        .clk           (clk),
        .rst           (rst),
        .accept        (accept),
        .op            (op),
        .src1          (src1),
        .src2          (src2),
        .imm           (imm),
        .pc            (pc),
        .redirect_vld  (redirect_vld),
        .redirect_addr (redirect_addr)
    );

    mem_agu mem_agu_inst (
        .op     (op),
        .src1   (src1),
        .src2   (src2),
        .imm    (imm),
        .addr   (agu_addr),
        .region (agu_region)
    );

    // store data is src2
    lsu_issue_reg lsu_issue_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .load        (mem_accept),
        .op          (op),
        .addr        (agu_addr),
        .region      (agu_region),
        .data        (src2),
        .wb_addr     (wb_addr),
        .wb_vld      (mem_wb_vld),
        .lsu_rdy     (lsu_rdy),
        .lsu_vld     (lsu_vld),
        .lsu_op      (lsu_op),
        .lsu_addr    (lsu_addr),
        .lsu_region  (lsu_region),
        .lsu_data    (lsu_data),
        .lsu_wb_addr (lsu_wb_addr),
        .lsu_wb_vld  (lsu_wb_vld)
    );

endmodule

`default_nettype wire

// File: verification/exu_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module exu_chk (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           wb_vld,
    input  wire logic                           redirect_vld,
    input  wire logic                           lsu_vld,
    input  wire logic                           lsu_rdy,
    input  wire logic [4:0]                     lsu_op,
    input  wire logic [`EXU_SRAM_ADDR_W-1:0]    lsu_addr,
    input  wire logic [1:0]                     lsu_region,
    input  wire logic [`EXU_XLEN-1:0]           lsu_data,
    input  wire logic [`EXU_REG_ADDR_W-1:0]     lsu_wb_addr,
    input  wire logic                           lsu_wb_vld
);

    int fail_count = 0;

    // stalled request must not move
    a_lsu_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_vld && !lsu_rdy |=> lsu_vld && $stable(lsu_op) && $stable(lsu_addr)
            && $stable(lsu_region) && $stable(lsu_data) && $stable(lsu_wb_addr)
            && $stable(lsu_wb_vld))
        else begin
            $error("lsu request changed while stalled");
            fail_count++;
        end

    a_redirect_pulse: assert property (@(posedge clk) disable iff (rst)
        redirect_vld |=> !redirect_vld)
        else begin
            $error("redirect_vld high on two consecutive cycles");
            fail_count++;
        end

    a_no_wb_on_flush: assert property (@(posedge clk) disable iff (rst)
        !(wb_vld && redirect_vld))
        else begin
            $error("writeback during a flush cycle");
            fail_count++;
        end

endmodule

bind exu_top exu_chk exu_chk_inst (
    .clk          (clk),
    .rst          (rst),
    .wb_vld       (wb_vld),
    .redirect_vld (redirect_vld),
    .lsu_vld      (lsu_vld),
    .lsu_rdy      (lsu_rdy),
    .lsu_op       (lsu_op),
    .lsu_addr     (lsu_addr),
    .lsu_region   (lsu_region),
    .lsu_data     (lsu_data),
    .lsu_wb_addr  (lsu_wb_addr),
    .lsu_wb_vld   (lsu_wb_vld)
);

`default_nettype wire

// File: verification/exu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module exu_tb import exu_pkg::*; ();

    localparam int WAIT_LIMIT = 200;
    localparam int MAX_VECS   = 64;

    logic                           clk;
    logic                           rst;
    logic                           in_vld;
    exu_op_e                        op;
    logic                           rd_en;
    logic [`EXU_XLEN-1:0]           src1;
    logic [`EXU_XLEN-1:0]           src2;
    logic [`EXU_XLEN-1:0]           imm;
    logic [`EXU_XLEN-1:0]           pc;
    logic [`EXU_REG_ADDR_W-1:0]     wb_addr;
    logic                           lsu_rdy;
    logic                           in_rdy;
    logic                           flush_vld;
    logic                           wb_vld;
    logic [`EXU_REG_ADDR_W-1:0]     wb_addr_out;
    logic [`EXU_XLEN-1:0]           wb_data;
    logic                           redirect_vld;
    logic [`EXU_SRAM_ADDR_W-1:0]    redirect_addr;
    logic                           lsu_vld;
    exu_op_e                        lsu_op;
    logic [`EXU_SRAM_ADDR_W-1:0]    lsu_addr;
    sram_region_e                   lsu_region;
    logic [`EXU_XLEN-1:0]           lsu_data;
    logic [`EXU_REG_ADDR_W-1:0]     lsu_wb_addr;
    logic                           lsu_wb_vld;

    logic [31:0] vecs [0:MAX_VECS-1][0:11];
    int          num_vecs;
    logic [31:0] rng_state;

    // expected lsu requests, oldest first
    logic [4:0]  q_op [$];
    logic [31:0] q_addr [$];
    logic [1:0]  q_region [$];
    logic [31:0] q_data [$];
    logic        q_store [$];
    logic        q_wbv [$];
    logic [4:0]  q_wba [$];

    // redirect expected at the negedge after an accept
    logic        pend_vld;
    logic        pend_taken;
    logic [31:0] pend_addr;
    logic        pend_mem;

    exu_top exu_top_inst (
        .clk           (clk),
        .rst           (rst),
        .in_vld        (in_vld),
        .op            (op),
        .rd_en         (rd_en),
        .src1          (src1),
        .src2          (src2),
        .imm           (imm),
        .pc            (pc),
        .wb_addr       (wb_addr),
        .in_rdy        (in_rdy),
        .flush_vld     (flush_vld),
        .wb_vld        (wb_vld),
        .wb_addr_out   (wb_addr_out),
        .wb_data       (wb_data),
        .redirect_vld  (redirect_vld),
        .redirect_addr (redirect_addr),
        .lsu_rdy       (lsu_rdy),
        .lsu_vld       (lsu_vld),
        .lsu_op        (lsu_op),
        .lsu_addr      (lsu_addr),
        .lsu_region    (lsu_region),
        .lsu_data      (lsu_data),
        .lsu_wb_addr   (lsu_wb_addr),
        .lsu_wb_vld    (lsu_wb_vld)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ready about three cycles out of four
    always @(posedge clk) begin
        rng_state = xorshift32(rng_state);
        lsu_rdy <= rng_state[0] | rng_state[1];
    end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic read_vectors();
        int    fd;
        int    n;
        string line;
        logic [31:0] f [0:11];
        fd = $fopen("verification/exu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verification/exu_tests.txt");
            $display("Test FAILED");
            $fatal(1, "no stimulus");
        end
        num_vecs = 0;
        while (!$feof(fd) && num_vecs < MAX_VECS) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5],
                            f[6], f[7], f[8], f[9], f[10], f[11]);
                if (n == 12) begin
                    for (int k = 0; k < 12; k++) begin
                        vecs[num_vecs][k] = f[k];
                    end
                    num_vecs++;
                end
            end
        end
        $fclose(fd);
        if (num_vecs == 0) begin
            $display("the stimulus file holds no instructions");
            $display("Test FAILED");
            $fatal(1, "empty stimulus");
        end
    endtask

    // called at every negedge, before looking at the current slot
    task automatic check_redirect_slot();
        if (pend_vld) begin
            check_eq("redirect_vld", redirect_vld, pend_taken);
            check_eq("flush_vld", flush_vld, pend_taken);
            if (pend_taken) begin
                check_eq("redirect_addr", redirect_addr, pend_addr);
            end
            if (pend_mem) begin
                check_eq("lsu_vld after accept", lsu_vld, 1'b1);
            end
            pend_vld = 1'b0;
        end else begin
            check_eq("redirect_vld unexpected", redirect_vld, 1'b0);
            check_eq("flush_vld unexpected", flush_vld, 1'b0);
        end
    endtask

    task automatic accept_checks(input int i);
        logic [4:0] opc;
        logic       is_mem;
        logic       is_br;
        logic       exp_wbv;
        opc     = vecs[i][0][4:0];
        is_mem  = (opc >= 5'h14) && (opc <= 5'h1b);
        is_br   = (opc >= 5'h0e) && (opc <= 5'h13);
        exp_wbv = vecs[i][1][0] && !is_mem && !is_br;
        check_eq("wb_vld", wb_vld, exp_wbv);
        if (exp_wbv) begin
            check_eq("wb_data", wb_data, vecs[i][7]);
            check_eq("wb_addr_out", wb_addr_out, vecs[i][6]);
        end
        if (is_mem) begin
            q_op.push_back(opc);
            q_addr.push_back(vecs[i][10]);
            q_region.push_back(vecs[i][11][1:0]);
            q_data.push_back(vecs[i][3]);
            q_store.push_back(opc >= 5'h19);
            q_wbv.push_back(vecs[i][1][0] && opc < 5'h19);
            q_wba.push_back(vecs[i][6][4:0]);
        end
        pend_vld   = 1'b1;
        pend_taken = vecs[i][8][0];
        pend_addr  = vecs[i][9];
        pend_mem   = is_mem;
    endtask

    // every completed transfer must match the oldest expected request
    always @(negedge clk) begin
        check_eq("bound assertion failures", exu_top_inst.exu_chk_inst.fail_count, 32'd0);
        if (!rst && lsu_vld && lsu_rdy) begin
            if (q_op.size() == 0) begin
                $display("lsu transfer with no memory op outstanding");
                $display("Test FAILED");
                $fatal(1, "extra transfer");
            end else begin
                check_eq("lsu_op", lsu_op, q_op[0]);
                check_eq("lsu_addr", lsu_addr, q_addr[0]);
                check_eq("lsu_region", lsu_region, q_region[0]);
                check_eq("lsu_wb_vld", lsu_wb_vld, q_wbv[0]);
                if (q_store[0]) begin
                    check_eq("lsu_data", lsu_data, q_data[0]);
                end
                if (q_wbv[0]) begin
                    check_eq("lsu_wb_addr", lsu_wb_addr, q_wba[0]);
                end
                void'(q_op.pop_front());
                void'(q_addr.pop_front());
                void'(q_region.pop_front());
                void'(q_data.pop_front());
                void'(q_store.pop_front());
                void'(q_wbv.pop_front());
                void'(q_wba.pop_front());
            end
        end
    end

    initial begin
        int  waited;
        logic done;
        clk       = 1'b0;
        rst       = 1'b1;
        in_vld    = 1'b0;
        op        = op_add;
        rd_en     = 1'b0;
        src1      = '0;
        src2      = '0;
        imm       = '0;
        pc        = '0;
        wb_addr   = '0;
        lsu_rdy   = 1'b0;
        rng_state = 32'd49499;
        pend_vld  = 1'b0;

        read_vectors();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq("lsu_vld after reset", lsu_vld, 1'b0);
        check_eq("redirect_vld after reset", redirect_vld, 1'b0);
        @(posedge clk);

        for (int i = 0; i < num_vecs; i++) begin
            in_vld  <= 1'b1;
            op      <= exu_op_e'(vecs[i][0][4:0]);
            rd_en   <= vecs[i][1][0];
            src1    <= vecs[i][2];
            src2    <= vecs[i][3];
            imm     <= vecs[i][4];
            pc      <= vecs[i][5];
            wb_addr <= vecs[i][6][4:0];
            done   = 1'b0;
            waited = 0;
            while (!done) begin
                @(negedge clk);
                check_redirect_slot();
                check_eq("in_rdy", in_rdy, lsu_rdy);
                if (redirect_vld) begin
                    // flushed slot, held and presented again
                    check_eq("wb_vld on flush", wb_vld, 1'b0);
                end else if (lsu_rdy) begin
                    accept_checks(i);
                    done = 1'b1;
                end else begin
                    check_eq("wb_vld on stall", wb_vld, 1'b0);
                end
                waited++;
                if (waited > WAIT_LIMIT) begin
                    give_up("an instruction to be accepted");
                end
                @(posedge clk);
            end
        end

        in_vld <= 1'b0;
        waited = 0;
        @(negedge clk);
        check_redirect_slot();
        while (q_op.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                give_up("the lsu requests to drain");
            end
        end
        @(negedge clk);
        check_eq("lsu_vld after drain", lsu_vld, 1'b0);
        check_eq("bound assertion failures", exu_top_inst.exu_chk_inst.fail_count, 32'd0);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hdl/exu_pkg.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/mem_agu.sv
hdl/lsu_issue_reg.sv
hdl/exu_top.sv
verification/exu_chk.sv
verification/exu_tb.sv

// File: verification/exu_tests.txt
# op rd_en src1 src2 imm pc wb_addr | exp: wb_data taken redirect_addr lsu_addr region
# all fields hex, one instruction per line
00 1 00000005 00000007 00000000 00000000 01 0000000c 0 000 000 0
01 1 00000005 00000007 00000000 00000004 02 fffffffe 0 000 000 0
02 1 ffffffff 00000001 00000000 00000008 03 00000001 0 000 000 0
03 1 ffffffff 00000001 00000000 0000000c 04 00000000 0 000 000 0
09 1 80000000 00000024 00000000 00000010 05 f8000000 0 000 000 0
08 1 80000000 00000004 00000000 00000014 06 08000000 0 000 000 0
04 1 f0f0f0f0 0ff00ff0 00000000 00000018 07 ff00ff00 0 000 000 0
0a 1 00000000 12345000 00000000 0000001c 08 12345000 0 000 000 0
0b 1 00000000 00001000 00000000 00000100 09 00001100 0 000 000 0
0c 1 00000000 00000040 00000000 00000200 0a 00000204 1 240 000 0
00 1 00000003 00000004 00000000 00000204 0b 00000007 0 000 000 0
0e 0 00000001 00000002 00000010 00000300 00 00000000 0 000 000 0
10 0 ffffffff 00000001 fffffff0 00000400 00 00000000 1 3f0 000 0
0d 1 00001000 00000024 00000000 00000500 0c 00000504 1 024 000 0
1b 0 00000100 deadbeef 00000020 00000504 00 00000000 0 000 120 0
16 1 00001000 00000010 00000000 00000508 0d 00000000 0 000 010 1
17 1 00002000 00000ffc 00000000 0000050c 0e 00000000 0 000 ffc 2
19 0 00003000 000000aa 00000004 00000510 00 00000000 0 000 004 3
1a 0 00000ff0 0000beef 00000020 00000514 00 00000000 0 000 010 1
13 0 ffffffff 00000001 00000008 00000600 00 00000000 1 608 000 0
05 1 0000f000 0000000f 00000000 00000608 0f 0000f00f 0 000 000 0
